// ==== rtl/rv_types_pkg.sv ====
// RV32I data-path widths and the vector types built on them

package rv_types_pkg;

  // machine word width
  localparam int XLEN = 32;

  // register index width and register count
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 2 ** REG_ADDR_W;

  // data and address value
  typedef logic [XLEN-1:0] word;

  // architectural register index
  typedef logic [REG_ADDR_W-1:0] reg_addr;

endpackage

// ==== rtl/rv_ctrl_pkg.sv ====
// RV32I control encodings shared by the decoder and the execute logic

package rv_ctrl_pkg;

  // follows funct3 of OP and OP-IMM so the decoder can cast directly
  typedef enum logic [2:0] {
    ALU_ADD  = 3'b000,
    ALU_SLL  = 3'b001,
    ALU_SLT  = 3'b010,
    ALU_SLTU = 3'b011,
    ALU_XOR  = 3'b100,
    ALU_SRL  = 3'b101,
    ALU_OR   = 3'b110,
    ALU_AND  = 3'b111
  } alu_op_t;

  // follows funct3 of the branch opcode
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } branch_op_t;

  // load/store access size
  typedef enum logic [1:0] {
    MEM_BYTE = 2'b00,
    MEM_HALF = 2'b01,
    MEM_WORD = 2'b10
  } mem_width_t;

  // alu operand a source
  typedef enum logic [1:0] {
    OPA_RS1,
    OPA_PC,
    OPA_ZERO
  } opa_sel_t;

  // alu operand b source
  typedef enum logic {
    OPB_RS2,
    OPB_IMM
  } opb_sel_t;

  // write-back source
  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PC4
  } wb_sel_t;

endpackage

// ==== rtl/rv_ctrl_if.sv ====
// Decoder control bundle that steers the ALU, data memory and write-back
`timescale 1ns/1ps

interface rv_ctrl_if import rv_ctrl_pkg::*; ();

  // alu
  alu_op_t    alu_op;
  logic       alu_alt;
  opa_sel_t   opa_sel;
  opb_sel_t   opb_sel;

  // control flow
  logic       branch;
  branch_op_t branch_op;
  logic       jump;

  // data memory
  logic       mem_read;
  logic       mem_write;
  mem_width_t mem_width;
  logic       mem_unsigned;

  // write-back
  wb_sel_t    wb_sel;
  logic       wb_en;

  modport dec (
    output alu_op, alu_alt, opa_sel, opb_sel,
    output branch, branch_op, jump,
    output mem_read, mem_write, mem_width, mem_unsigned,
    output wb_sel, wb_en
  );

  modport exe (
    input alu_op, alu_alt, opa_sel, opb_sel,
    input branch, branch_op, jump,
    input mem_read, mem_write, mem_width, mem_unsigned,
    input wb_sel, wb_en
  );

endinterface

// ==== rtl/rv_decoder.sv ====
// RV32I decoder producing register indices, the immediate and the control bundle
`timescale 1ns/1ps

module rv_decoder import rv_types_pkg::*, rv_ctrl_pkg::*; (
  input  word     instr,
  output reg_addr rs1,
  output reg_addr rs2,
  output reg_addr rd,
  output word     imm,
  rv_ctrl_if.dec  ctrl
);

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7_b5;
  mem_width_t acc_width;
  word        imm_i;
  word        imm_s;
  word        imm_b;
  word        imm_u;
  word        imm_j;

  assign opcode    = instr[6:0];
  assign funct3    = instr[14:12];
  assign funct7_b5 = instr[30];

  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign rd  = instr[11:7];

  // I, S, B and J immediates sign-extend from bit 31
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // funct3[1:0] picks the size and funct3[2] the zero extension
  assign acc_width = (funct3[1:0] == 2'b00) ? MEM_BYTE :
                     (funct3[1:0] == 2'b01) ? MEM_HALF : MEM_WORD;

  always_comb begin
    imm               = '0;
    ctrl.alu_op       = ALU_ADD;
    ctrl.alu_alt      = 1'b0;
    ctrl.opa_sel      = OPA_RS1;
    ctrl.opb_sel      = OPB_IMM;
    ctrl.branch       = 1'b0;
    ctrl.branch_op    = BR_EQ;
    ctrl.jump         = 1'b0;
    ctrl.mem_read     = 1'b0;
    ctrl.mem_write    = 1'b0;
    ctrl.mem_width    = MEM_WORD;
    ctrl.mem_unsigned = 1'b0;
    ctrl.wb_sel       = WB_ALU;
    ctrl.wb_en        = 1'b0;

    case (opcode)
      OPC_LUI: begin
        imm          = imm_u;
        ctrl.opa_sel = OPA_ZERO;
        ctrl.wb_en   = 1'b1;
      end
      OPC_AUIPC: begin
        imm          = imm_u;
        ctrl.opa_sel = OPA_PC;
        ctrl.wb_en   = 1'b1;
      end
      OPC_JAL: begin
        imm          = imm_j;
        ctrl.opa_sel = OPA_PC;
        ctrl.jump    = 1'b1;
        ctrl.wb_sel  = WB_PC4;
        ctrl.wb_en   = 1'b1;
      end
      OPC_JALR: begin
        imm         = imm_i;
        ctrl.jump   = 1'b1;
        ctrl.wb_sel = WB_PC4;
        ctrl.wb_en  = 1'b1;
      end
      OPC_BRANCH: begin
        // alu forms the target while the compare runs on rs1/rs2
        imm            = imm_b;
        ctrl.opa_sel   = OPA_PC;
        ctrl.branch    = 1'b1;
        ctrl.branch_op = branch_op_t'(funct3);
      end
      OPC_LOAD: begin
        imm               = imm_i;
        ctrl.mem_read     = 1'b1;
        ctrl.mem_width    = acc_width;
        ctrl.mem_unsigned = funct3[2];
        ctrl.wb_sel       = WB_MEM;
        ctrl.wb_en        = 1'b1;
      end
      OPC_STORE: begin
        imm            = imm_s;
        ctrl.mem_write = 1'b1;
        ctrl.mem_width = acc_width;
      end
      OPC_OP_IMM: begin
        imm          = imm_i;
        ctrl.alu_op  = alu_op_t'(funct3);
        // only srai uses bit 30 since for addi it is part of the immediate
        ctrl.alu_alt = (funct3 == 3'b101) && funct7_b5;
        ctrl.wb_en   = 1'b1;
      end
      OPC_OP: begin
        ctrl.opb_sel = OPB_RS2;
        ctrl.alu_op  = alu_op_t'(funct3);
        ctrl.alu_alt = funct7_b5;
        ctrl.wb_en   = 1'b1;
      end
      // fence, system and anything unknown fall through as no-ops
      default: begin
      end
    endcase
  end

endmodule

// ==== rtl/rv_regfile.sv ====
// RV32I register file with two read ports and write-through bypass
`timescale 1ns/1ps

module rv_regfile import rv_types_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  input  logic    we,
  input  reg_addr waddr,
  input  word     wdata,
  input  reg_addr raddr1,
  input  reg_addr raddr2,
  output word     rdata1,
  output word     rdata2
);

  // x0 has no storage
  word regs_q [1:NUM_REGS-1];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs_q[waddr] <= wdata;
    end
  end

  // new data wins when reading the register being written this cycle
  assign rdata1 = (raddr1 == '0)                ? '0    :
                  (we && waddr == raddr1)       ? wdata :
                                                  regs_q[raddr1];

  assign rdata2 = (raddr2 == '0)                ? '0    :
                  (we && waddr == raddr2)       ? wdata :
                                                  regs_q[raddr2];

endmodule

// ==== rtl/rv_alu.sv ====
// RV32I ALU with the branch compare and taken decision
`timescale 1ns/1ps

module rv_alu import rv_types_pkg::*, rv_ctrl_pkg::*; (
  input  word           a,
  input  word           b,
  input  word           rs1,
  input  word           rs2,
  rv_ctrl_if.exe        ctrl,
  output word           res,
  output logic          take_branch
);

  logic [4:0] shamt;
  word        sra_res;
  logic       cond;

  assign shamt = b[4:0];

  // arithmetic shift keeps the sign of a
  assign sra_res = $signed(a) >>> shamt;

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:  res = ctrl.alu_alt ? a - b : a + b;
      ALU_SLL:  res = a << shamt;
      ALU_SLT:  res = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: res = {31'b0, a < b};
      ALU_XOR:  res = a ^ b;
      ALU_SRL:  res = ctrl.alu_alt ? sra_res : a >> shamt;
      ALU_OR:   res = a | b;
      ALU_AND:  res = a & b;
      default:  res = '0;
    endcase
  end

  // register compare for conditional branches
  always_comb begin
    case (ctrl.branch_op)
      BR_EQ:   cond = rs1 == rs2;
      BR_NE:   cond = rs1 != rs2;
      BR_LT:   cond = $signed(rs1) < $signed(rs2);
      BR_GE:   cond = $signed(rs1) >= $signed(rs2);
      BR_LTU:  cond = rs1 < rs2;
      BR_GEU:  cond = rs1 >= rs2;
      default: cond = 1'b0;
    endcase
  end

  assign take_branch = ctrl.jump || (ctrl.branch && cond);

endmodule

// ==== rtl/rv_dmem.sv ====
// Byte-lane data memory with sized access, load extension and alignment check
`timescale 1ns/1ps

module rv_dmem import rv_types_pkg::*, rv_ctrl_pkg::*; #(
  parameter int DMEM_ADDR_W = 10
) (
  input  logic   clk,
  input  word    addr,
  input  word    wdata,
  rv_ctrl_if.exe ctrl,
  output word    rdata,
  output logic   misaligned
);

  localparam int DEPTH = 2 ** (DMEM_ADDR_W - 2);

  word                    mem_q [DEPTH];
  logic [DMEM_ADDR_W-3:0] idx;
  logic [1:0]             off;
  logic                   align_err;
  logic [3:0]             be;
  word                    lane_data;
  word                    rd_word;
  word                    shifted;

  // upper address bits are dropped
  assign idx = addr[DMEM_ADDR_W-1:2];
  assign off = addr[1:0];

  always_comb begin
    case (ctrl.mem_width)
      MEM_BYTE: align_err = 1'b0;
      MEM_HALF: align_err = off[0];
      default:  align_err = off != 2'b00;
    endcase
  end

  assign misaligned = (ctrl.mem_read || ctrl.mem_write) && align_err;

  // lane enables plus store data replicated across the lanes
  always_comb begin
    case (ctrl.mem_width)
      MEM_BYTE: begin
        be        = 4'b0001 << off;
        lane_data = {4{wdata[7:0]}};
      end
      MEM_HALF: begin
        be        = 4'b0011 << off;
        lane_data = {2{wdata[15:0]}};
      end
      default: begin
        be        = 4'b1111;
        lane_data = wdata;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (ctrl.mem_write && !misaligned) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i]) begin
          mem_q[idx][8*i +: 8] <= lane_data[8*i +: 8];
        end
      end
    end
  end

  // asynchronous read with the addressed lane moved down to bit 0
  assign rd_word = mem_q[idx];
  assign shifted = rd_word >> {off, 3'b000};

  always_comb begin
    case (ctrl.mem_width)
      MEM_BYTE: rdata = {{24{!ctrl.mem_unsigned && shifted[7]}}, shifted[7:0]};
      MEM_HALF: rdata = {{16{!ctrl.mem_unsigned && shifted[15]}}, shifted[15:0]};
      default:  rdata = rd_word;
    endcase
  end

endmodule

// ==== rtl/rv_core.sv ====
// RV32I core top that executes one instruction per cycle with registered write-back
`timescale 1ns/1ps

module rv_core import rv_types_pkg::*, rv_ctrl_pkg::*; #(
  parameter int  DMEM_ADDR_W = 10,
  parameter word RESET_PC    = '0
) (
  input  logic    clk,
  input  logic    arst_n,
  output word     pc,
  input  word     instr,
  output logic    wb_valid,
  output reg_addr wb_rd,
  output word     wb_data,
  output logic    mem_fault
);

  word     pc_q;
  word     pc_next;
  word     pc_plus_4;
  reg_addr dec_rs1;
  reg_addr dec_rs2;
  reg_addr dec_rd;
  word     dec_imm;
  word     rf_rdata1;
  word     rf_rdata2;
  word     opa;
  word     opb;
  word     alu_res;
  logic    take_branch;
  word     dmem_rdata;
  logic    dmem_misaligned;
  word     wb_mux;
  logic    wb_valid_q;
  reg_addr wb_rd_q;
  word     wb_data_q;
  logic    mem_fault_q;

  rv_ctrl_if ctrl ();

  rv_decoder decoder_i (
    .instr (instr),
    .rs1   (dec_rs1),
    .rs2   (dec_rs2),
    .rd    (dec_rd),
    .imm   (dec_imm),
    .ctrl  (ctrl)
  );

  // written from the registered write-back stage
  rv_regfile regfile_i (
    .clk    (clk),
    .arst_n (arst_n),
    .we     (wb_valid_q),
    .waddr  (wb_rd_q),
    .wdata  (wb_data_q),
    .raddr1 (dec_rs1),
    .raddr2 (dec_rs2),
    .rdata1 (rf_rdata1),
    .rdata2 (rf_rdata2)
  );

  always_comb begin
    case (ctrl.opa_sel)
      OPA_PC:   opa = pc_q;
      OPA_ZERO: opa = '0;
      default:  opa = rf_rdata1;
    endcase
  end

  assign opb = (ctrl.opb_sel == OPB_RS2) ? rf_rdata2 : dec_imm;

  rv_alu alu_i (
    .a           (opa),
    .b           (opb),
    .rs1         (rf_rdata1),
    .rs2         (rf_rdata2),
    .ctrl        (ctrl),
    .res         (alu_res),
    .take_branch (take_branch)
  );

  rv_dmem #(
    .DMEM_ADDR_W (DMEM_ADDR_W)
  ) dmem_i (
    .clk        (clk),
    .addr       (alu_res),
    .wdata      (rf_rdata2),
    .ctrl       (ctrl),
    .rdata      (dmem_rdata),
    .misaligned (dmem_misaligned)
  );

  always_comb begin
    case (ctrl.wb_sel)
      WB_MEM:  wb_mux = dmem_rdata;
      WB_PC4:  wb_mux = pc_plus_4;
      default: wb_mux = alu_res;
    endcase
  end

  // jalr is the only jump that takes rs1 as its base
  assign pc_plus_4 = pc_q + 32'd4;
  assign pc_next   = !take_branch                             ? pc_plus_4 :
                     (ctrl.jump && ctrl.opa_sel == OPA_RS1)   ? {alu_res[31:1], 1'b0} :
                                                                alu_res;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_q        <= RESET_PC;
      wb_valid_q  <= 1'b0;
      mem_fault_q <= 1'b0;
    end else begin
      pc_q        <= pc_next;
      // neither a faulting load nor a write to x0 is reported
      wb_valid_q  <= ctrl.wb_en && !dmem_misaligned && (dec_rd != '0);
      mem_fault_q <= dmem_misaligned;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd_q   <= dec_rd;
    wb_data_q <= wb_mux;
  end

  assign pc        = pc_q;
  assign wb_valid  = wb_valid_q;
  assign wb_rd     = wb_rd_q;
  assign wb_data   = wb_data_q;
  assign mem_fault = mem_fault_q;

endmodule

// ==== bench/rv_core_tb.sv ====
// Testbench for the RV32I core, serving a program and checking ordered write-backs and faults
`timescale 1ns/1ps

module rv_core_tb import rv_types_pkg::*; ();

  localparam int         CASE_WORDS = 256;
  localparam int         PROG_BASE  = 'h10;
  localparam int         REC_BASE   = 'h80;
  localparam int         DRAIN      = 4;
  localparam logic [3:0] KIND_WB    = 4'h1;
  localparam logic [3:0] KIND_FAULT = 4'h2;
  localparam word        NOP        = 32'h0000_0013;
  // jal x0,0 parks the core past the end of the program
  localparam word        SELF_JUMP  = 32'h0000_006f;

  logic    clk;
  logic    arst_n;
  word     pc;
  word     instr;
  logic    wb_valid;
  reg_addr wb_rd;
  word     wb_data;
  logic    mem_fault;

  logic [47:0] case_mem [CASE_WORDS];
  int          prog_len;
  int          rec_len;
  int          rec_idx;
  int          cycles;
  int          limit;
  int          mismatch_errs;
  int          other_errs;

  rv_core rv_core_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .pc        (pc),
    .instr     (instr),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .mem_fault (mem_fault)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  function automatic string test_name(logic [3:0] idx);
    case (idx)
      4'h1:    return "alu";
      4'h2:    return "jump";
      4'h3:    return "branch";
      4'h4:    return "memory";
      4'h5:    return "fault";
      4'h6:    return "x0";
      default: return "unknown";
    endcase
  endfunction

  // instruction memory model indexed by word address
  function automatic word fetch(word addr);
    int idx;
    idx = int'(addr >> 2);
    if (idx < prog_len) begin
      return case_mem[PROG_BASE + idx][31:0];
    end
    return SELF_JUMP;
  endfunction

  task automatic check_wb(string name, reg_addr exp_rd, word exp_data);
    if (wb_rd !== exp_rd || wb_data !== exp_data) begin
      mismatch_errs++;
      $display("MISMATCH %s: expected x%0d = 0x%08h, actual x%0d = 0x%08h",
               name, exp_rd, exp_data, wb_rd, wb_data);
    end
  endtask

  task automatic check_fault(string name);
    if (wb_valid !== 1'b0) begin
      mismatch_errs++;
      $display("MISMATCH %s: expected wb_valid 0 with the fault, actual %b", name, wb_valid);
    end
  endtask

  task automatic check_pc(string name, word exp_pc);
    if (pc !== exp_pc) begin
      mismatch_errs++;
      $display("MISMATCH %s: expected pc 0x%08h, actual pc 0x%08h", name, exp_pc, pc);
    end
  endtask

  // pairs one observed event with the next expected record
  task automatic take_record(logic is_fault);
    logic [47:0] rec;
    string       name;
    if (rec_idx >= rec_len) begin
      other_errs++;
      $display("unexpected %s event with no expected record left (x%0d, pc 0x%08h)",
               is_fault ? "fault" : "write-back", wb_rd, pc);
    end else begin
      rec  = case_mem[REC_BASE + rec_idx];
      name = test_name(rec[47:44]);
      rec_idx++;
      if (is_fault && rec[43:40] == KIND_FAULT) begin
        check_fault(name);
      end else if (!is_fault && rec[43:40] == KIND_WB) begin
        check_wb(name, reg_addr'(rec[36:32]), rec[31:0]);
      end else begin
        other_errs++;
        $display("test %s: saw a %s where the next record expects the other kind",
                 name, is_fault ? "memory fault" : "write-back");
      end
    end
  endtask

  // pc has settled since the rising edge
  always @(negedge clk) begin
    instr = fetch(pc);
  end

  always @(negedge clk) begin
    if (arst_n) begin
      if (mem_fault) begin
        take_record(1'b1);
      end else if (wb_valid) begin
        take_record(1'b0);
      end
    end
  end

  initial begin
    arst_n        = 1'b0;
    instr         = NOP;
    rec_idx       = 0;
    mismatch_errs = 0;
    other_errs    = 0;
    $readmemh("bench/rv_core_cases.txt", case_mem);
    prog_len = int'(case_mem[0][31:0]);
    rec_len  = int'(case_mem[1][31:0]);
    if (prog_len <= 0 || prog_len > REC_BASE - PROG_BASE ||
        rec_len <= 0 || rec_len > CASE_WORDS - REC_BASE) begin
      other_errs++;
      $display("cases file is missing or its header lengths are out of range");
      prog_len = 0;
      rec_len  = 0;
    end
    limit = 4 * prog_len + 20;

    repeat (4) @(negedge clk);
    // state held by reset before release
    check_pc("reset", '0);
    if (wb_valid !== 1'b0 || mem_fault !== 1'b0) begin
      other_errs++;
      $display("wb_valid or mem_fault is high while reset is asserted");
    end
    arst_n = 1'b1;

    cycles = 0;
    while (rec_idx < rec_len && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    // a few more cycles to catch write-backs nobody expected
    repeat (DRAIN) @(negedge clk);

    // past the last word the core parks on the self-jump
    check_pc("park", word'(4 * prog_len));

    if (rec_idx < rec_len) begin
      other_errs++;
      $display("timeout after %0d cycles, %0d expected write-backs or faults were missing",
               cycles, rec_len - rec_idx);
    end
    $display("errors: %0d mismatches, %0d other", mismatch_errs, other_errs);
    if (mismatch_errs == 0 && other_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== rv_core.f ====
rtl/rv_types_pkg.sv
rtl/rv_ctrl_pkg.sv
rtl/rv_ctrl_if.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_dmem.sv
rtl/rv_core.sv
bench/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - files:
      - rtl/rv_types_pkg.sv
      - rtl/rv_ctrl_pkg.sv
      - rtl/rv_ctrl_if.sv
      - rtl/rv_decoder.sv
      - rtl/rv_regfile.sv
      - rtl/rv_alu.sv
      - rtl/rv_dmem.sv
      - rtl/rv_core.sv
  - target: test
    files:
      - bench/rv_core_tb.sv

// ==== bench/rv_core_cases.txt ====
// @000 program length, record count. @010 program words in address order
// @080 records TKRRVVVVVVVV: T test 1 alu 2 jump 3 branch 4 memory 5 fault 6 x0,
// K kind 1 write-back 2 fault, RR destination register, V expected value
@000
00000036 0000001d
@010
// addi x1,x0,-5; addi x2,x0,3; sub x3,x2,x1; sra x4,x1,x2; slt x5,x1,x2
ffb00093 00300113 401101b3 4020d233 0020a2b3
// sltu x6,x1,x2; srli x7,x1,28; xori x8,x7,0x5a; srai x9,x1,1; add x10,x3,x8
0020b333 01c0d393 05a3c413 4010d493 00818533
// lui x11,0x12345; auipc x12,1; jal x13,+12; two skipped addi x14
123455b7 00001617 00c006ef 00100713 00200713
// jalr x15,17(x13) to 0x44 over a skipped addi; addi x14,x0,4
011687e7 00300713 00400713
// triplets of branch not taken, branch taken +8, skipped addi x16,x0,-1
// beq, bne, blt, then marker addi x16,x0,1
00208463 00108463 fff00813
00109463 00209463 fff00813
00114463 0020c463 fff00813
00100813
// bge, bltu, bgeu, then marker addi x16,x0,2
0020d463 00115463 fff00813
0020e463 00116463 fff00813
00117463 0020f463 fff00813
00200813
// lui x17,0x8badf; addi x17,x17,13; sw x17,0x100(x0); lw x18,0x100(x0)
8badf8b7 00d88893 11102023 10002903
// lb x19,0x101; lbu x20,0x103; lh x21,0x102; lhu x22,0x100
10100983 10304a03 10201a83 10005b03
// sb x2,0x102; sh x1,0x100; lw x23,0x100
10200123 10101023 10002b83
// misaligned lh x24,0x101 and sw x2,0x102, then lw x24,0x100
10101c03 10202123 10002c03
// addi x0,x0,0x123; add x25,x0,x2
12300013 00200cb3
@080
1101fffffffb 110200000003 110300000008 1104ffffffff 110500000001
110600000000 11070000000f 110800000055 1109fffffffd 110a0000005d
210b12345000 210c0000102c 210d00000034 210f00000040 210e00000004
311000000001 311000000002
41118badf000 41118badf00d 41128badf00d 4113fffffff0 41140000008b
4115ffff8bad 41160000f00d 41178b03fffb
520000000000 520000000000 51188b03fffb
611900000003
